// File: common/modmul_config.svh
`ifndef MODMUL_CONFIG_SVH
`define MODMUL_CONFIG_SVH

// Radix of each coefficient word
`define WORD_BITS 8

// Words in one binary residue
`define NUM_WORDS 4

// Extra carry bits kept per coefficient
`define REDUN_BITS 1

// Address width of each reduction table
`define REDUCTION_BITS 9

// Fixed odd modulus, at least 2^31 so the final subtract loop stays short
`define MODULUS 32'hF1E2_D3C5

// Width of the squaring count T
`define ITER_BITS 8

// Credit counts handed out after reset
`define IN_CREDITS 1
`define OUT_CREDITS 2
`define CREDIT_BITS 3

`endif

// File: common/redun_pkg.sv
`include "modmul_config.svh"

package redun_pkg;

  // One coefficient: a radix word plus its redundant carry bits
  typedef logic [`WORD_BITS+`REDUN_BITS-1:0] coef_t;

  // Redundant operand, one spare coefficient on top for carries
  // Value is the sum of coef[i] * 2^(i*WORD_BITS)
  typedef coef_t [`NUM_WORDS:0] redun_t;

  // Plain binary residue
  typedef logic [`NUM_WORDS*`WORD_BITS-1:0] res_t;

endpackage

// File: common/ctrl_pkg.sv
`include "modmul_config.svh"

package ctrl_pkg;

  // Squaring count of one job
  typedef logic [`ITER_BITS-1:0] iter_t;

  // Flow control credit counter
  typedef logic [`CREDIT_BITS-1:0] credit_t;

  // Job slot sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_SQUARE,
    SEQ_WAIT,
    SEQ_HANDOFF
  } seq_state_e;

  // Redundant to binary converter
  typedef enum logic [1:0] {
    CONV_IDLE,
    CONV_RESOLVE,
    CONV_SUBTRACT,
    CONV_SEND
  } conv_state_e;

endpackage

// File: modmul/reduction_lut.sv
`timescale 1ns/10ps
`include "modmul_config.svh"

module reduction_lut #(
  // Column index of the coefficient this table folds
  parameter int COLUMN = 0,
  // Which REDUCTION_BITS slice of that coefficient
  parameter int CHUNK = 0
) (
  input  logic                       i_clk,
  input  logic [`REDUCTION_BITS-1:0] i_addr,
  output redun_pkg::res_t            o_res
);

  localparam int DEPTH = 1 << `REDUCTION_BITS;
  // Bit weight of address 1
  localparam int SHIFT = COLUMN * `WORD_BITS + CHUNK * `REDUCTION_BITS;
  localparam int WIDE_BITS = SHIFT + `REDUCTION_BITS;

  redun_pkg::res_t table_mem [DEPTH];
  logic [`REDUCTION_BITS-1:0] addr_q;

  // Entry k holds (k << SHIFT) mod N
  initial begin
    logic [WIDE_BITS-1:0] shifted;
    for (int k = 0; k < DEPTH; k++) begin
      shifted = WIDE_BITS'(k) << SHIFT;
      table_mem[k] = redun_pkg::res_t'(shifted % WIDE_BITS'(`MODULUS));
    end
  end

  always_ff @(posedge i_clk) begin
    addr_q <= i_addr;
  end

  // Read straight from the registered address
  assign o_res = table_mem[addr_q];

endmodule

// File: modmul/poly_mod_mult.sv
`timescale 1ns/10ps
`include "modmul_config.svh"

module poly_mod_mult #(
  // Square i_dat_a only, i_dat_b ignored
  parameter bit SQ_MODE = 1
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  redun_pkg::redun_t i_dat_a,
  input  redun_pkg::redun_t i_dat_b,
  output redun_pkg::redun_t o_dat,
  output logic              o_val
);

  localparam int WORD_BITS = `WORD_BITS;
  localparam int NUM_WORDS = `NUM_WORDS;
  localparam int I_WORD = NUM_WORDS + 1;
  localparam int COEF_BITS = WORD_BITS + `REDUN_BITS;
  localparam int PROD_BITS = 2 * COEF_BITS;
  // Word pieces a single coefficient product spans
  localparam int NUM_SHIFTS = (PROD_BITS + WORD_BITS - 1) / WORD_BITS;
  // Columns hit by product pieces, then one more for the carry out
  localparam int ACC_COLS = 2 * I_WORD + NUM_SHIFTS - 2;
  localparam int CARRY_COLS = ACC_COLS + 1;
  // At most NUM_SHIFTS * I_WORD word pieces land in one column
  localparam int ACCUM_BITS = WORD_BITS + $clog2(NUM_SHIFTS * I_WORD);
  // Columns at or above NUM_WORDS are folded back through tables
  localparam int NUM_HIGH = CARRY_COLS - NUM_WORDS;
  localparam int REDUCTION_STAGES = (COEF_BITS + `REDUCTION_BITS - 1) / `REDUCTION_BITS;
  localparam int ADDR_PAD_BITS = REDUCTION_STAGES * `REDUCTION_BITS;
  localparam int RED_BITS = WORD_BITS + $clog2(NUM_HIGH * REDUCTION_STAGES + 2);
  localparam int LATENCY = 6;

  logic [LATENCY-1:0] val_q;

  // Input registers
  redun_pkg::redun_t a_q;
  redun_pkg::redun_t b_q;

  // Stage 1 partial products, one per coefficient pair
  logic [I_WORD-1:0][I_WORD-1:0][PROD_BITS-1:0] prod_comb, prod_q;

  // Stage 2 column sums
  logic [ACC_COLS-1:0][ACCUM_BITS-1:0] accum_comb, accum_q;

  // Stage 3 one level of carry, low columns kept, high columns to tables
  logic [CARRY_COLS-1:0][COEF_BITS-1:0] carry_comb;
  logic [NUM_WORDS-1:0][COEF_BITS-1:0] low_q;
  logic [NUM_HIGH-1:0][ADDR_PAD_BITS-1:0] high_pad;

  // Table outputs, congruent residues of each high chunk
  redun_pkg::res_t lut_res [NUM_HIGH][REDUCTION_STAGES];

  // Stage 4 low columns plus folded residues
  logic [NUM_WORDS-1:0][RED_BITS-1:0] red_comb, red_q;

  // Stage 5 final carry step
  redun_pkg::redun_t out_comb, out_q;

  // Valid walks alongside the data
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else begin
      val_q <= {val_q[LATENCY-2:0], i_val};
    end
  end

  always_ff @(posedge i_clk) begin
    a_q <= i_dat_a;
    b_q <= i_dat_b;
    prod_q <= prod_comb;
    accum_q <= accum_comb;
    low_q <= carry_comb[NUM_WORDS-1:0];
    red_q <= red_comb;
    out_q <= out_comb;
  end

  // Squaring skips pairs above the diagonal, stage 2 doubles those below it
  always_comb begin
    logic [COEF_BITS-1:0] b_coef;
    prod_comb = '0;
    for (int i = 0; i < I_WORD; i++) begin
      for (int j = 0; j < I_WORD; j++) begin
        b_coef = SQ_MODE ? a_q[j] : b_q[j];
        if (!(SQ_MODE && i < j)) begin
          prod_comb[i][j] = PROD_BITS'(a_q[i]) * PROD_BITS'(b_coef);
        end
      end
    end
  end

  // Split each product into word pieces and add them into their columns
  always_comb begin
    logic [NUM_SHIFTS*WORD_BITS-1:0] piece_src;
    accum_comb = '0;
    for (int i = 0; i < I_WORD; i++) begin
      for (int j = 0; j < I_WORD; j++) begin
        piece_src = '0;
        piece_src[PROD_BITS-1:0] = prod_q[i][j];
        for (int k = 0; k < NUM_SHIFTS; k++) begin
          if (SQ_MODE && i > j) begin
            accum_comb[i+j+k] += ACCUM_BITS'({piece_src[k*WORD_BITS +: WORD_BITS], 1'b0});
          end else begin
            accum_comb[i+j+k] += ACCUM_BITS'(piece_src[k*WORD_BITS +: WORD_BITS]);
          end
        end
      end
    end
  end

  // Each column keeps its low word and takes the overflow of the one below
  always_comb begin
    carry_comb = '0;
    for (int c = 0; c < ACC_COLS; c++) begin
      carry_comb[c] += COEF_BITS'(accum_q[c][WORD_BITS-1:0]);
      carry_comb[c+1] += COEF_BITS'(accum_q[c][ACCUM_BITS-1:WORD_BITS]);
    end
  end

  always_comb begin
    for (int h = 0; h < NUM_HIGH; h++) begin
      high_pad[h] = ADDR_PAD_BITS'(carry_comb[NUM_WORDS+h]);
    end
  end

  // Tables register their chunk address here, same edge as low_q
  for (genvar h = 0; h < NUM_HIGH; h++) begin : g_col
    for (genvar s = 0; s < REDUCTION_STAGES; s++) begin : g_chunk
      reduction_lut #(
        .COLUMN(NUM_WORDS + h),
        .CHUNK (s)
      ) lut_i (
        .i_clk (i_clk),
        .i_addr(high_pad[h][s*`REDUCTION_BITS +: `REDUCTION_BITS]),
        .o_res (lut_res[h][s])
      );
    end
  end

  // Add every table residue word by word onto the low columns
  always_comb begin
    red_comb = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      red_comb[i] = RED_BITS'(low_q[i]);
      for (int h = 0; h < NUM_HIGH; h++) begin
        for (int s = 0; s < REDUCTION_STAGES; s++) begin
          red_comb[i] += RED_BITS'(lut_res[h][s][i*WORD_BITS +: WORD_BITS]);
        end
      end
    end
  end

  // Top coefficient only collects the last carry
  always_comb begin
    out_comb = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      out_comb[i] += COEF_BITS'(red_q[i][WORD_BITS-1:0]);
      out_comb[i+1] += COEF_BITS'(red_q[i][RED_BITS-1:WORD_BITS]);
    end
  end

  assign o_dat = out_q;
  assign o_val = val_q[LATENCY-1];

endmodule

// File: source/square_sequencer.sv
`timescale 1ns/10ps
`include "modmul_config.svh"

module square_sequencer (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_in_val,
  input  redun_pkg::res_t   i_in_x,
  input  ctrl_pkg::iter_t   i_in_iters,
  output logic              o_in_credit,
  output logic              o_sq_val,
  output redun_pkg::redun_t o_sq_dat,
  input  logic              i_mul_val,
  input  redun_pkg::redun_t i_mul_dat,
  input  logic              i_conv_ready,
  output logic              o_conv_val,
  output redun_pkg::redun_t o_conv_dat
);

  ctrl_pkg::seq_state_e state_q;
  // Squarings still to do
  ctrl_pkg::iter_t count_q;
  // The one operand slot
  redun_pkg::redun_t slot_q;
  redun_pkg::redun_t x_redun;

  // Binary x as redundant, carry bits and top coefficient zero
  always_comb begin
    x_redun = '0;
    for (int i = 0; i < `NUM_WORDS; i++) begin
      x_redun[i] = redun_pkg::coef_t'(i_in_x[i*`WORD_BITS +: `WORD_BITS]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ctrl_pkg::SEQ_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ctrl_pkg::SEQ_IDLE: begin
          if (i_in_val) begin
            count_q <= i_in_iters;
            // T of zero skips the loop
            if (i_in_iters == '0) begin
              state_q <= ctrl_pkg::SEQ_HANDOFF;
            end else begin
              state_q <= ctrl_pkg::SEQ_SQUARE;
            end
          end
        end
        ctrl_pkg::SEQ_SQUARE: begin
          state_q <= ctrl_pkg::SEQ_WAIT;
        end
        ctrl_pkg::SEQ_WAIT: begin
          if (i_mul_val) begin
            count_q <= count_q - 1'b1;
            if (count_q == ctrl_pkg::iter_t'(1)) begin
              state_q <= ctrl_pkg::SEQ_HANDOFF;
            end else begin
              state_q <= ctrl_pkg::SEQ_SQUARE;
            end
          end
        end
        ctrl_pkg::SEQ_HANDOFF: begin
          // Converter busy means the job waits here
          if (i_conv_ready) begin
            state_q <= ctrl_pkg::SEQ_IDLE;
          end
        end
        default: begin
          state_q <= ctrl_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // Load x on a new job, then overwrite with each square
  always_ff @(posedge i_clk) begin
    if (state_q == ctrl_pkg::SEQ_IDLE && i_in_val) begin
      slot_q <= x_redun;
    end else if (state_q == ctrl_pkg::SEQ_WAIT && i_mul_val) begin
      slot_q <= i_mul_dat;
    end
  end

  // One issue per iteration, product comes back 6 cycles later
  assign o_sq_val = (state_q == ctrl_pkg::SEQ_SQUARE);
  assign o_sq_dat = slot_q;

  // Hand-off frees the slot, so the input credit goes back the same cycle
  assign o_conv_val = (state_q == ctrl_pkg::SEQ_HANDOFF) && i_conv_ready;
  assign o_conv_dat = slot_q;
  assign o_in_credit = o_conv_val;

endmodule

// File: source/redun_to_bin.sv
`timescale 1ns/10ps
`include "modmul_config.svh"

module redun_to_bin (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  redun_pkg::redun_t i_dat,
  output logic              o_ready,
  output logic              o_out_val,
  output redun_pkg::res_t   o_out_res,
  input  logic              i_out_credit
);

  localparam int RES_BITS = `NUM_WORDS * `WORD_BITS;
  // Top coefficient sits at 2^RES_BITS, plus one bit of headroom
  localparam int ACC_BITS = RES_BITS + `WORD_BITS + `REDUN_BITS + 1;
  localparam logic [ACC_BITS-1:0] MOD_WIDE = ACC_BITS'(`MODULUS);

  ctrl_pkg::conv_state_e state_q;
  ctrl_pkg::credit_t credit_q;
  redun_pkg::redun_t dat_q;
  logic [ACC_BITS-1:0] acc_q;
  logic [ACC_BITS-1:0] sum_comb;
  logic acc_ge_n;
  logic send;

  // Carry resolve by plain weighted addition
  always_comb begin
    sum_comb = '0;
    for (int i = 0; i <= `NUM_WORDS; i++) begin
      sum_comb += ACC_BITS'(dat_q[i]) << (i * `WORD_BITS);
    end
  end

  assign acc_ge_n = (acc_q >= MOD_WIDE);
  assign send = (state_q == ctrl_pkg::CONV_SEND) && (credit_q != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ctrl_pkg::CONV_IDLE;
      credit_q <= ctrl_pkg::credit_t'(`OUT_CREDITS);
    end else begin
      case (state_q)
        ctrl_pkg::CONV_IDLE: if (i_val) state_q <= ctrl_pkg::CONV_RESOLVE;
        ctrl_pkg::CONV_RESOLVE: state_q <= ctrl_pkg::CONV_SUBTRACT;
        ctrl_pkg::CONV_SUBTRACT: if (!acc_ge_n) state_q <= ctrl_pkg::CONV_SEND;
        ctrl_pkg::CONV_SEND: if (send) state_q <= ctrl_pkg::CONV_IDLE;
        default: state_q <= ctrl_pkg::CONV_IDLE;
      endcase
      // Returned and spent in one cycle cancel out
      if (i_out_credit && !send) begin
        credit_q <= credit_q + 1'b1;
      end else if (!i_out_credit && send) begin
        credit_q <= credit_q - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == ctrl_pkg::CONV_IDLE && i_val) dat_q <= i_dat;
    if (state_q == ctrl_pkg::CONV_RESOLVE) begin
      acc_q <= sum_comb;
    end else if (state_q == ctrl_pkg::CONV_SUBTRACT && acc_ge_n) begin
      // One N per cycle until the residue is below N
      acc_q <= acc_q - MOD_WIDE;
    end
  end

  assign o_ready = (state_q == ctrl_pkg::CONV_IDLE);
  assign o_out_val = send;
  assign o_out_res = acc_q[RES_BITS-1:0];

endmodule

// File: source/vdf_core.sv
`timescale 1ns/10ps

module vdf_core (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_in_val,
  input  redun_pkg::res_t i_in_x,
  input  ctrl_pkg::iter_t i_in_iters,
  output logic            o_in_credit,
  output logic            o_out_val,
  output redun_pkg::res_t o_out_res,
  input  logic            i_out_credit
);

  // Loop between sequencer and multiplier
  logic              sq_val;
  redun_pkg::redun_t sq_dat;
  logic              mul_val;
  redun_pkg::redun_t mul_dat;

  // Finished value into the converter
  logic              conv_val;
  logic              conv_ready;
  redun_pkg::redun_t conv_dat;

  square_sequencer seq_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_in_val    (i_in_val),
    .i_in_x      (i_in_x),
    .i_in_iters  (i_in_iters),
    .o_in_credit (o_in_credit),
    .o_sq_val    (sq_val),
    .o_sq_dat    (sq_dat),
    .i_mul_val   (mul_val),
    .i_mul_dat   (mul_dat),
    .i_conv_ready(conv_ready),
    .o_conv_val  (conv_val),
    .o_conv_dat  (conv_dat)
  );

  // Square only, b side just mirrors a
  poly_mod_mult #(
    .SQ_MODE(1)
  ) mul_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_val  (sq_val),
    .i_dat_a(sq_dat),
    .i_dat_b(sq_dat),
    .o_dat  (mul_dat),
    .o_val  (mul_val)
  );

  redun_to_bin conv_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_val       (conv_val),
    .i_dat       (conv_dat),
    .o_ready     (conv_ready),
    .o_out_val   (o_out_val),
    .o_out_res   (o_out_res),
    .i_out_credit(i_out_credit)
  );

endmodule

// File: bench/tb_vdf_core.sv
`timescale 1ns/10ps
`include "modmul_config.svh"

module tb_vdf_core;

  localparam int CLK_HALF = 10;
  localparam int DRIVE_DELAY = 1;
  localparam int RESET_CYCLES = 5;
  localparam logic [31:0] MODULUS = `MODULUS;
  // Job mix of the whole run with two directed jobs first
  localparam int RANDOM_JOBS = 20;
  localparam int HELD_JOBS = 4;
  localparam int TOTAL_JOBS = RANDOM_JOBS + HELD_JOBS + 2;
  localparam int MAX_ITERS = 16;
  localparam int HOLD_CYCLES = 300;
  localparam int MAX_RETURN_GAP = 20;
  // Each job gets 8 cycles per squaring plus room for converter and credit gaps
  localparam int TIMEOUT_CYCLES = TOTAL_JOBS * (MAX_ITERS * 8 + 60) + HOLD_CYCLES + 200;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_in_val;
  logic [31:0]           i_in_x;
  logic [`ITER_BITS-1:0] i_in_iters;
  logic                  o_in_credit;
  logic                  o_out_val;
  logic [31:0]           o_out_res;
  logic                  i_out_credit;

  integer      seed;
  int          err_count;
  int          cycle_count;
  int          jobs_sent;
  int          results;
  int          in_credit_count;
  // Source side view of the input credits
  int          credits_held;
  // Output credits handed to the DUT so far including the initial ones
  int          credits_given;
  int          returns_done;
  int          return_wait;
  bit          hold_credits;
  logic [31:0] exp_q[$];
  string       name_q[$];

  vdf_core dut_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_in_val    (i_in_val),
    .i_in_x      (i_in_x),
    .i_in_iters  (i_in_iters),
    .o_in_credit (o_in_credit),
    .o_out_val   (o_out_val),
    .o_out_res   (o_out_res),
    .i_out_credit(i_out_credit)
  );

  always #CLK_HALF i_clk = ~i_clk;

  // Expected x^(2^T) mod N
  // Squares stay below 2^64 since N < 2^32
  function automatic logic [31:0] square_chain_mod(input logic [31:0] x,
                                                   input logic [`ITER_BITS-1:0] iters);
    logic [63:0] acc;
    acc = {32'd0, x};
    for (int i = 0; i < int'(iters); i++) begin
      acc = (acc * acc) % {32'd0, MODULUS};
    end
    return acc[31:0];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic end_report();
    $display("jobs %0d, results %0d, input credits %0d, output credits %0d, errors %0d",
             jobs_sent, results, in_credit_count, credits_given, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // Spends one input credit and waits for one if none is held
  task automatic send_job(input logic [31:0] x, input logic [`ITER_BITS-1:0] iters,
                          input logic [31:0] exp, input string name);
    while (credits_held == 0) begin
      @(posedge i_clk);
      #DRIVE_DELAY;
    end
    i_in_val = 1'b1;
    i_in_x = x;
    i_in_iters = iters;
    exp_q.push_back(exp);
    name_q.push_back(name);
    jobs_sent++;
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_in_val = 1'b0;
  endtask

  // All results back and all output credits returned
  task automatic wait_drained();
    while (exp_q.size() != 0 || returns_done != results) begin
      @(posedge i_clk);
      #DRIVE_DELAY;
    end
  endtask

  // Credit bookkeeping and result compare on the clock edge
  always @(posedge i_clk) begin
    if (!i_rst) begin
      // An input credit returned on this same edge is not yet usable
      if (i_in_val) begin
        if (credits_held == 0) begin
          $display("Input job was sent while the source held no input credit");
          err_count++;
        end else begin
          credits_held--;
        end
      end
      if (o_in_credit) begin
        credits_held++;
        in_credit_count++;
      end
      if (o_out_val) begin
        results++;
        // A credit returned on this same edge is not yet usable
        if (results > credits_given) begin
          $display("Result %0d was sent without an output credit", results);
          err_count++;
        end
        if (exp_q.size() == 0) begin
          $display("Result %h appeared with no job outstanding", o_out_res);
          err_count++;
        end else begin
          compare_value(name_q.pop_front(), exp_q.pop_front(), o_out_res);
        end
      end
      if (i_out_credit) begin
        credits_given++;
      end
    end
  end

  // Sink gives each credit back after a random gap unless held
  initial begin
    i_out_credit = 1'b0;
    returns_done = 0;
    return_wait = 0;
    forever begin
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_out_credit = 1'b0;
      if (!i_rst && !hold_credits && returns_done < results) begin
        if (return_wait == 0) begin
          i_out_credit = 1'b1;
          returns_done++;
          return_wait = {$random(seed)} % (MAX_RETURN_GAP + 1);
        end else begin
          return_wait--;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles, the DUT stopped making progress", cycle_count);
      err_count++;
      end_report();
    end
  end

  initial begin
    logic [31:0]           rand_x;
    logic [`ITER_BITS-1:0] rand_t;
    seed = 32'hb2ba_bc20;
    err_count = 0;
    cycle_count = 0;
    jobs_sent = 0;
    results = 0;
    in_credit_count = 0;
    credits_held = `IN_CREDITS;
    credits_given = `OUT_CREDITS;
    hold_credits = 1'b0;
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_in_val = 1'b0;
    i_in_x = '0;
    i_in_iters = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst = 1'b0;
    // Quiet period where any result would have no job behind it
    repeat (20) @(posedge i_clk);
    #DRIVE_DELAY;
    send_job(32'd3, `ITER_BITS'(1), 32'd9, "three_squared");
    send_job(MODULUS - 1, '0, MODULUS - 1, "zero_iterations");
    for (int n = 0; n < RANDOM_JOBS; n++) begin
      rand_x = {$random(seed)} % MODULUS;
      rand_t = `ITER_BITS'({$random(seed)} % (MAX_ITERS + 1));
      send_job(rand_x, rand_t, square_chain_mod(rand_x, rand_t), "random_job");
    end
    wait_drained();
    // DUT now holds its full output credit so returns are withheld
    hold_credits = 1'b1;
    for (int n = 0; n < HELD_JOBS; n++) begin
      rand_x = {$random(seed)} % MODULUS;
      rand_t = `ITER_BITS'({$random(seed)} % (MAX_ITERS + 1));
      send_job(rand_x, rand_t, square_chain_mod(rand_x, rand_t), "held_job");
    end
    repeat (HOLD_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    // Two results leave on the initial credits and two wait
    compare_value("held_results", 32'(credits_given), 32'(results));
    compare_value("held_pending", 32'(HELD_JOBS - `OUT_CREDITS), 32'(exp_q.size()));
    hold_credits = 1'b0;
    wait_drained();
    compare_value("input_credit_returns", 32'(jobs_sent), 32'(in_credit_count));
    compare_value("job_count", 32'(TOTAL_JOBS), 32'(results));
    end_report();
  end

endmodule

// File: verilog.f
+incdir+common
common/redun_pkg.sv
common/ctrl_pkg.sv
modmul/reduction_lut.sv
modmul/poly_mod_mult.sv
source/square_sequencer.sv
source/redun_to_bin.sv
source/vdf_core.sv
bench/tb_vdf_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vdf_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vdf_core -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_vdf_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
